// File: bitscan_pkg.sv
// Fixed at a 32-bit bitmap and an 8-entry result queue; the RESULT word assumes INDEX_W <= 31
package bitscan_pkg;

    // Bitmap and bus widths
    localparam int BITMAP_W = 32;
    localparam int INDEX_W  = $clog2(BITMAP_W);
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 2;

    // Result queue sizing
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int COUNT_W    = PTR_W + 1;

    typedef logic [BITMAP_W-1:0] bitmap_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [ADDR_W-1:0]   wb_addr_t;
    typedef logic [DATA_W-1:0]   wb_data_t;

    // Word addresses on the Wishbone port
    localparam wb_addr_t ADDR_BITMAP = 2'd0;
    localparam wb_addr_t ADDR_CTRL   = 2'd1;
    localparam wb_addr_t ADDR_STATUS = 2'd2;
    localparam wb_addr_t ADDR_RESULT = 2'd3;

    // CTRL fields
    localparam int CTRL_MSB_BIT   = 0;
    localparam int CTRL_ABORT_BIT = 1;

    // STATUS fields, count sits in bits 7:4
    localparam int STAT_BUSY_BIT    = 0;
    localparam int STAT_EMPTY_BIT   = 1;
    localparam int STAT_OVERRUN_BIT = 2;
    localparam int STAT_COUNT_LSB   = 4;

    // RESULT valid flag
    localparam int RESULT_VALID_BIT = DATA_W - 1;

    typedef enum logic {
        ENG_IDLE,
        ENG_SCAN
    } eng_state_t;

endpackage

// File: priority_arbiter.sv
// Purely combinational; grant and index settle in the same cycle as the request vector
`timescale 1ns/10ps

module priority_arbiter import bitscan_pkg::*; (
    input  bitmap_t req_i,
    input  logic    msb_first_i,
    output bitmap_t grant_o,
    output index_t  idx_o,
    output logic    any_o
);

    bitmap_t req_m;
    bitmap_t grant_m;

    // Mirror the requests so the highest bit becomes bit 0 in msb-first mode
    always_comb begin
        for (int i = 0; i < BITMAP_W; i++) begin
            req_m[i] = msb_first_i ? req_i[BITMAP_W-1-i] : req_i[i];
        end
    end

    // Lowest set bit survives, all others cancel
    assign grant_m = req_m & (~req_m + 1'b1);

    // Undo the mirror on the grant
    always_comb begin
        for (int i = 0; i < BITMAP_W; i++) begin
            grant_o[i] = msb_first_i ? grant_m[BITMAP_W-1-i] : grant_m[i];
        end
    end

    // One-hot to binary, OR of the positions of set grant bits
    always_comb begin
        idx_o = '0;
        for (int i = 0; i < BITMAP_W; i++) begin
            if (grant_o[i]) begin
                idx_o = idx_o | index_t'(i);
            end
        end
    end

    assign any_o = |req_i;

endmodule

// File: bitscan_regs.sv
// Wishbone classic slave, full words only; accepts at most one access every other cycle
`timescale 1ns/10ps

module bitscan_regs import bitscan_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    input  logic     busy_i,
    input  logic     empty_i,
    input  count_t   count_i,
    input  index_t   head_i,
    output logic     load_o,
    output bitmap_t  load_data_o,
    output logic     msb_first_o,
    output logic     abort_o,
    output logic     pop_o
);

    logic     req;
    logic     wr_bitmap;
    logic     wr_ctrl;
    logic     rd_result;
    logic     overrun;
    wb_data_t rd_data;

    // A request is new only outside the ack cycle of the previous one
    assign req       = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_bitmap = req & wb_we_i & (wb_adr_i == ADDR_BITMAP);
    assign wr_ctrl   = req & wb_we_i & (wb_adr_i == ADDR_CTRL);
    assign rd_result = req & ~wb_we_i & (wb_adr_i == ADDR_RESULT);

    // Queue pops on the same edge that raises ack
    assign pop_o = rd_result & ~empty_i;

    // Read mux, sampled into wb_dat_o with the request
    always_comb begin
        rd_data = '0;
        if (!wb_we_i) begin
            case (wb_adr_i)
                ADDR_STATUS: begin
                    rd_data[STAT_BUSY_BIT]    = busy_i;
                    rd_data[STAT_EMPTY_BIT]   = empty_i;
                    rd_data[STAT_OVERRUN_BIT] = overrun;
                    rd_data[STAT_COUNT_LSB +: COUNT_W] = count_i;
                end
                ADDR_RESULT: begin
                    // Head before the pop
                    if (!empty_i) begin
                        rd_data[RESULT_VALID_BIT] = 1'b1;
                        rd_data[INDEX_W-1:0]      = head_i;
                    end
                end
                default: begin
                    rd_data = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_o    <= 1'b0;
            load_o      <= 1'b0;
            abort_o     <= 1'b0;
            msb_first_o <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            wb_ack_o <= req;
            // Bitmap only accepted while the engine is idle
            load_o   <= wr_bitmap & ~busy_i;
            abort_o  <= wr_ctrl & wb_dat_i[CTRL_ABORT_BIT];
            if (wr_ctrl) begin
                msb_first_o <= wb_dat_i[CTRL_MSB_BIT];
                overrun     <= 1'b0;
            end else if (wr_bitmap && busy_i) begin
                // Dropped write, flag stays until the next CTRL write
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
        if (wr_bitmap) begin
            load_data_o <= wb_dat_i;
        end
    end

endmodule

// File: bitscan_engine.sv
// Direction is latched at load, so a CTRL write during a scan only affects the next bitmap
`timescale 1ns/10ps

module bitscan_engine import bitscan_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    load_i,
    input  bitmap_t load_data_i,
    input  logic    msb_first_i,
    input  logic    abort_i,
    input  logic    full_i,
    output logic    push_o,
    output index_t  push_idx_o,
    output logic    busy_o
);

    eng_state_t state;
    bitmap_t    work;
    logic       scan_msb;
    bitmap_t    grant;
    index_t     idx;
    logic       any;
    logic       step;
    bitmap_t    remaining;

    priority_arbiter i_priority_arbiter (
        .req_i       (work),
        .msb_first_i (scan_msb),
        .grant_o     (grant),
        .idx_o       (idx),
        .any_o       (any)
    );

    assign busy_o = (state == ENG_SCAN);

    // One index per cycle unless the queue is full
    assign step       = busy_o & any & ~full_i & ~abort_i;
    assign push_o     = step;
    assign push_idx_o = idx;

    // Bitmap left after the granted bit is cleared
    assign remaining = work & ~grant;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ENG_IDLE;
        end else if (abort_i) begin
            state <= ENG_IDLE;
        end else begin
            case (state)
                ENG_IDLE: begin
                    // An all-zero bitmap never starts a scan
                    if (load_i && (load_data_i != '0)) begin
                        state <= ENG_SCAN;
                    end
                end
                ENG_SCAN: begin
                    // Leave on the edge that clears the last bit
                    if (!any || (step && (remaining == '0))) begin
                        state <= ENG_IDLE;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Working bitmap and scan direction
    always_ff @(posedge clk_i) begin
        if (abort_i) begin
            work <= '0;
        end else if ((state == ENG_IDLE) && load_i) begin
            work     <= load_data_i;
            scan_msb <= msb_first_i;
        end else if (step) begin
            work <= remaining;
        end
    end

endmodule

// File: index_fifo.sv
// Depth must be a power of two, the pointers wrap by overflow; flush has priority over push and pop
`timescale 1ns/10ps

module index_fifo import bitscan_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   push_i,
    input  index_t push_idx_i,
    input  logic   pop_i,
    input  logic   flush_i,
    output index_t head_o,
    output logic   full_o,
    output logic   empty_o,
    output count_t count_o
);

    index_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_o == count_t'(FIFO_DEPTH));
    assign empty_o = (count_o == '0);
    assign head_o  = mem[rd_ptr];

    // A push into a full queue only goes through alongside a pop
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: begin
                    count_o <= count_o + 1'b1;
                end
                2'b01: begin
                    count_o <= count_o - 1'b1;
                end
                default: begin
                    count_o <= count_o;
                end
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem[wr_ptr] <= push_idx_i;
        end
    end

endmodule

// File: bitscan_top.sv
// Single Wishbone classic slave; abort in CTRL also flushes every queued index
`timescale 1ns/10ps

module bitscan_top import bitscan_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o
);

    logic    load;
    bitmap_t load_data;
    logic    msb_first;
    logic    abort;
    logic    pop;
    logic    push;
    index_t  push_idx;
    logic    busy;
    logic    full;
    logic    empty;
    count_t  count;
    index_t  head;

    bitscan_regs i_bitscan_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .busy_i      (busy),
        .empty_i     (empty),
        .count_i     (count),
        .head_i      (head),
        .load_o      (load),
        .load_data_o (load_data),
        .msb_first_o (msb_first),
        .abort_o     (abort),
        .pop_o       (pop)
    );

    bitscan_engine i_bitscan_engine (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .load_i      (load),
        .load_data_i (load_data),
        .msb_first_i (msb_first),
        .abort_i     (abort),
        .full_i      (full),
        .push_o      (push),
        .push_idx_o  (push_idx),
        .busy_o      (busy)
    );

    index_fifo i_index_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .push_i     (push),
        .push_idx_i (push_idx),
        .pop_i      (pop),
        .flush_i    (abort),
        .head_o     (head),
        .full_o     (full),
        .empty_o    (empty),
        .count_o    (count)
    );

endmodule

// File: bitscan_checker.sv
// Compares STATUS and RESULT reads in issue order; reads of other addresses are not checked
`timescale 1ns/10ps

module bitscan_checker import bitscan_pkg::*; (
    input logic     clk_i,
    input logic     wb_cyc_i,
    input logic     wb_stb_i,
    input logic     wb_we_i,
    input wb_addr_t wb_adr_i,
    input wb_data_t wb_rdata_i,
    input logic     wb_ack_i
);

    wb_data_t exp_q[$];
    int       error_count  = 0;
    int       test_errors  = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;

    // Charge one failure to the current test
    task automatic record_error();
        test_errors = test_errors + 1;
        error_count = error_count + 1;
    endtask

    // Queue one expected read word
    task automatic expect_read(input wb_data_t value);
        exp_q.push_back(value);
    endtask

    // Close a test and print its line
    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected reads never arrived", name, exp_q.size());
            record_error();
            exp_q.delete();
        end
        if (test_errors == 0) begin
            tests_passed = tests_passed + 1;
            $display("PASS %s", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("FAIL %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
    endtask

    // Data and ack are both stable at the falling edge
    initial begin : monitor
        string    reg_name;
        wb_data_t exp_word;
        forever begin
            @(negedge clk_i);
            if (wb_cyc_i && wb_stb_i && wb_ack_i && !wb_we_i &&
                (wb_adr_i == ADDR_STATUS || wb_adr_i == ADDR_RESULT)) begin
                reg_name = (wb_adr_i == ADDR_STATUS) ? "STATUS" : "RESULT";
                if (exp_q.size() == 0) begin
                    $display("%s read arrived with no expected value queued", reg_name);
                    record_error();
                end else begin
                    exp_word = exp_q.pop_front();
                    if (wb_rdata_i !== exp_word) begin
                        $display("** Error: wb_dat_o (%s) = 0x%08h, expected 0x%08h",
                                 reg_name, wb_rdata_i, exp_word);
                        record_error();
                    end
                end
            end
        end
    end

    // Ack follows one waiting cycle of the request and lasts one cycle
    initial begin : ack_monitor
        int   wait_cycles;
        logic prev_ack;
        wait_cycles = 0;
        prev_ack    = 1'b0;
        forever begin
            @(negedge clk_i);
            if (wb_ack_i) begin
                if (prev_ack || wait_cycles == 0) begin
                    $display("** Error: wb_ack_o = 0x1, expected 0x0");
                    record_error();
                end
                wait_cycles = 0;
            end else if (wb_cyc_i && wb_stb_i) begin
                wait_cycles = wait_cycles + 1;
                if (wait_cycles == 2) begin
                    $display("** Error: wb_ack_o = 0x0, expected 0x1");
                    record_error();
                end
            end
            prev_ack = wb_ack_i;
        end
    end

endmodule

// File: bitscan_tb.sv
// Single Wishbone master, one access at a time; the run length bounds every wait
`timescale 1ns/10ps

module bitscan_tb import bitscan_pkg::*; ();

    localparam int CLK_HALF_NS     = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int N_LSB_RANDOM    = 6;
    localparam int N_MSB_RANDOM    = 4;
    localparam int NUM_TESTS       = 1 + N_LSB_RANDOM + 2 + N_MSB_RANDOM + 4;
    localparam int WATCHDOG_NS     = NUM_TESTS * 40 * 4 * 8 + 2000;
    localparam int DRAIN_LIMIT     = 40;
    // Queue fills within 8 pushes of the load
    localparam int FILL_WAIT       = 16;

    logic     clk_i;
    logic     reset_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;

    logic [31:0] rng_state;
    index_t      ref_list[$];

    bitscan_top i_bitscan_top (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    bitscan_checker i_checker (
        .clk_i      (clk_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_rdata_i (wb_dat_o),
        .wb_ack_i   (wb_ack_o)
    );

    always #(CLK_HALF_NS) clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bitmap_t next_bitmap();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Set-bit positions in scan order
    function automatic void expected_indices(input bitmap_t bm, input logic msb);
        int pos;
        ref_list.delete();
        for (int n = 0; n < 32; n++) begin
            pos = msb ? (31 - n) : n;
            if (bm[pos]) begin
                ref_list.push_back(index_t'(pos));
            end
        end
    endfunction

    function automatic wb_data_t status_word(input logic busy, input logic empty,
                                             input logic overrun, input logic [3:0] count);
        return {24'd0, count, 1'b0, overrun, empty, busy};
    endfunction

    function automatic wb_data_t result_word(input index_t idx);
        return {1'b1, 26'd0, idx};
    endfunction

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = data;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        data = wb_dat_o;
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic expect_status(input wb_data_t value);
        wb_data_t rd;
        i_checker.expect_read(value);
        wb_read(ADDR_STATUS, rd);
    endtask

    // Reference list, then the zero word of the empty queue
    task automatic queue_expected();
        foreach (ref_list[i]) begin
            i_checker.expect_read(result_word(ref_list[i]));
        end
        i_checker.expect_read('0);
    endtask

    task automatic drain_results();
        wb_data_t rd;
        int       reads;
        reads = 0;
        do begin
            wb_read(ADDR_RESULT, rd);
            reads++;
        end while (rd[31] && reads < DRAIN_LIMIT);
    endtask

    task automatic run_scan(input string name, input bitmap_t bm, input logic msb);
        wb_write(ADDR_CTRL, {31'd0, msb});
        wb_write(ADDR_BITMAP, bm);
        expected_indices(bm, msb);
        queue_expected();
        drain_results();
        i_checker.end_test(name);
    endtask

    initial begin
        wb_data_t rd;
        clk_i     = 1'b0;
        reset_i   = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        rng_state = 32'hb234;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        expect_status(status_word(1'b0, 1'b1, 1'b0, 4'd0));
        i_checker.end_test("reset_status");

        for (int i = 0; i < N_LSB_RANDOM; i++) begin
            run_scan($sformatf("lsb_random_%0d", i), next_bitmap(), 1'b0);
        end
        run_scan("msb_zero", '0, 1'b1);
        run_scan("msb_ones", '1, 1'b1);
        for (int i = 0; i < N_MSB_RANDOM; i++) begin
            run_scan($sformatf("msb_random_%0d", i), next_bitmap(), 1'b1);
        end

        // Queue full, engine stalled but still busy
        wb_write(ADDR_CTRL, 32'd0);
        wb_write(ADDR_BITMAP, 32'h0F0F_3C3C);
        repeat (FILL_WAIT) @(posedge clk_i);
        expect_status(status_word(1'b1, 1'b0, 1'b0, 4'd8));
        expected_indices(32'h0F0F_3C3C, 1'b0);
        queue_expected();
        drain_results();
        expect_status(status_word(1'b0, 1'b1, 1'b0, 4'd0));
        i_checker.end_test("backpressure");

        // Second bitmap lands while busy
        wb_write(ADDR_CTRL, 32'd0);
        wb_write(ADDR_BITMAP, 32'hFFFF_0000);
        wb_write(ADDR_BITMAP, 32'h0000_FFFF);
        repeat (FILL_WAIT) @(posedge clk_i);
        expect_status(status_word(1'b1, 1'b0, 1'b1, 4'd8));
        expected_indices(32'hFFFF_0000, 1'b0);
        queue_expected();
        drain_results();
        expect_status(status_word(1'b0, 1'b1, 1'b1, 4'd0));
        wb_write(ADDR_CTRL, 32'd0);
        expect_status(status_word(1'b0, 1'b1, 1'b0, 4'd0));
        i_checker.end_test("overrun");

        wb_write(ADDR_CTRL, 32'd0);
        wb_write(ADDR_BITMAP, '1);
        repeat (4) @(posedge clk_i);
        wb_write(ADDR_CTRL, 32'h0000_0002);
        expect_status(status_word(1'b0, 1'b1, 1'b0, 4'd0));
        i_checker.expect_read('0);
        wb_read(ADDR_RESULT, rd);
        i_checker.end_test("abort");

        // Empty pop first, then a normal scan
        i_checker.expect_read('0);
        wb_read(ADDR_RESULT, rd);
        run_scan("empty_read", next_bitmap(), 1'b1);

        i_checker.report_counts();
        if (i_checker.error_count == 0 && i_checker.tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: bitscan_top.f
bitscan_pkg.sv
priority_arbiter.sv
bitscan_regs.sv
bitscan_engine.sv
index_fifo.sv
bitscan_top.sv
bitscan_checker.sv
bitscan_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, the result is taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/10ps --top-module bitscan_tb -f bitscan_top.f \
    --Mdir obj_dir -o bitscan_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/bitscan_sim > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "Checks failed" sim.log \
    && { echo "Simulation reported failures, see sim.log"; exit 1; }

grep -q "All checks passed" sim.log \
    || { echo "Simulation ended without a result, see sim.log"; exit 1; }

echo "Simulation passed, see sim.log"
exit 0
